// File: filelist.f
logic/acq_pkg.sv
logic/regs_pkg.sv
logic/saturating_adder.sv
logic/calibration.sv
logic/calib_regs.sv
logic/sample_fifo.sv
logic/acq_frontend.sv
tests/tb_acq_frontend.sv

// File: logic/acq_frontend.sv
//////////////////////////////////////////////////
// Acquisition front end top, register block feeding
// the calibration stage and the output FIFO
//////////////////////////////////////////////////
`timescale 1ns/1ps

module acq_frontend import acq_pkg::*, regs_pkg::*; (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [wb_adr_w-1:0]           wb_adr,
    input  logic [regs_pkg::wb_dat_w-1:0] wb_dat_w,
    output logic [regs_pkg::wb_dat_w-1:0] wb_dat_r,
    output logic                          wb_ack,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  sample_t                       in_data,
    output logic                          out_valid,
    input  logic                          out_ready,
    output sample_t                       out_data
);

    // Settings from the register block
    sample_t            offset;
    logic [shift_w-1:0] gain_shift;
    logic               gain_enable;
    logic               flush;
    logic [count_w-1:0] fifo_count;

    // Calibrated stream into the FIFO
    logic               cal_valid;
    logic               cal_ready;
    sample_t            cal_data;

    calib_regs u_regs (
        .clock (clock), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .fifo_count (fifo_count), .offset (offset), .gain_shift (gain_shift),
        .gain_enable (gain_enable), .flush (flush)
    );

    calibration u_calibration (
        .clock (clock), .rst (rst), .flush (flush),
        .offset (offset), .gain_shift (gain_shift), .gain_enable (gain_enable),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data),
        .cal_valid (cal_valid), .cal_ready (cal_ready), .cal_data (cal_data)
    );

    // The FIFO write side back-pressures the calibration stage
    sample_fifo u_fifo (
        .clock (clock), .rst (rst), .flush (flush),
        .wr_valid (cal_valid), .wr_ready (cal_ready), .wr_data (cal_data),
        .rd_valid (out_valid), .rd_ready (out_ready), .rd_data (out_data),
        .count (fifo_count)
    );

endmodule

// File: logic/acq_pkg.sv
//////////////////////////////////////////////////
// Data path definitions for the acquisition front
// end: sample type, saturation limits and FIFO size
//////////////////////////////////////////////////
package acq_pkg;

    // One ADC sample is a single signed 16-bit word
    localparam int sample_w = 16;
    typedef logic signed [sample_w-1:0] sample_t;

    // Clamp limits used when the offset sum overflows
    localparam sample_t sample_max = {1'b0, {(sample_w-1){1'b1}}};
    localparam sample_t sample_min = {1'b1, {(sample_w-1){1'b0}}};

    // Gain is a left shift of 0 to 15 positions
    localparam int shift_w = 4;

    // Output buffer geometry, the count must be able to hold a full FIFO
    localparam int fifo_depth = 8;
    localparam int count_w = 4;
    localparam int ptr_w = $clog2(fifo_depth);

endpackage

// File: logic/calib_regs.sv
//////////////////////////////////////////////////
// Wishbone classic register block holding offset,
// gain and flush settings plus the FIFO status
//////////////////////////////////////////////////
`timescale 1ns/1ps

module calib_regs import acq_pkg::*, regs_pkg::*; (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [wb_adr_w-1:0]           wb_adr,
    input  logic [regs_pkg::wb_dat_w-1:0] wb_dat_w,
    output logic [regs_pkg::wb_dat_w-1:0] wb_dat_r,
    output logic                          wb_ack,
    input  logic [count_w-1:0]            fifo_count,
    output sample_t                       offset,
    output logic [shift_w-1:0]            gain_shift,
    output logic                          gain_enable,
    output logic                          flush
);

    logic                          access;
    logic                          write_en;
    logic [regs_pkg::wb_dat_w-1:0] read_word;

    // A cycle is served once, the held strobe is ignored while ack is up
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign write_en = access && wb_we;

    // Read data is selected by address and registered with the ack
    always_comb begin
        read_word = '0;
        case (wb_adr)
            reg_offset: read_word = offset;
            reg_gain: begin
                read_word[shift_w-1:0] = gain_shift;
                read_word[gain_enable_bit] = gain_enable;
            end
            reg_control: read_word = '0;
            reg_status: read_word[count_w-1:0] = fifo_count;
            default: read_word = '0;
        endcase
    end

    // Handshake and settings, all written on the edge that raises ack
    always_ff @(posedge clock) begin
        if (rst) begin
            wb_ack <= 1'b0;
            offset <= '0;
            gain_shift <= '0;
            gain_enable <= 1'b0;
            flush <= 1'b0;
        end else begin
            wb_ack <= access;
            // The flush pulse lasts one cycle and acts on the next edge
            flush <= write_en && (wb_adr == reg_control) && wb_dat_w[flush_bit];
            if (write_en && wb_adr == reg_offset) begin
                offset <= wb_dat_w;
            end
            if (write_en && wb_adr == reg_gain) begin
                gain_shift <= wb_dat_w[shift_w-1:0];
                gain_enable <= wb_dat_w[gain_enable_bit];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            wb_dat_r <= read_word;
        end
    end

    // Every ack answers a strobe seen one cycle earlier and is never doubled
    assert property (@(posedge clock) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb) && !$past(wb_ack))
        else $error("wb_ack without a preceding cyc and stb");

endmodule

// File: logic/calibration.sv
//////////////////////////////////////////////////
// Calibration stage, saturating offset correction
// and optional shift gain, one register of latency
//////////////////////////////////////////////////
`timescale 1ns/1ps

module calibration import acq_pkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               flush,
    input  sample_t            offset,
    input  logic [shift_w-1:0] gain_shift,
    input  logic               gain_enable,
    input  logic               in_valid,
    output logic               in_ready,
    input  sample_t            in_data,
    output logic               cal_valid,
    input  logic               cal_ready,
    output sample_t            cal_data
);

    sample_t offset_sum;
    sample_t gained;

    // The stage has a single register, so it can only take a new sample
    // when the downstream side takes the one it holds
    assign in_ready = cal_ready;

    saturating_adder u_offset_adder (
        .a   (in_data),
        .b   (offset),
        .sum (offset_sum)
    );

    // Bits shifted out above the sample width are simply lost
    assign gained = offset_sum << gain_shift;

    // Valid flag of the output register
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            cal_valid <= 1'b0;
        end else if (cal_ready) begin
            // The held sample leaves now; refill only if a new one is offered
            cal_valid <= in_valid;
        end
    end

    // Sample payload, loaded on every accepted input transfer
    always_ff @(posedge clock) begin
        if (in_valid && cal_ready) begin
            cal_data <= gain_enable ? gained : offset_sum;
        end
    end

    // A flush or reset must leave the stage empty on the following cycle
    // so that no stale sample reaches the FIFO
    assert property (@(posedge clock) (rst || flush) |=> !cal_valid)
        else $error("cal_valid high after flush or reset");

endmodule

// File: logic/regs_pkg.sv
//////////////////////////////////////////////////
// Register map of the calibration settings as seen
// from the Wishbone configuration bus
//////////////////////////////////////////////////
package regs_pkg;

    // Word addressed bus with four registers of 16 bits
    localparam int wb_adr_w = 2;
    localparam int wb_dat_w = 16;

    // Signed offset coefficient, read and write
    localparam logic [wb_adr_w-1:0] reg_offset = 2'd0;
    // Gain shift in the low nibble and the enable flag above it
    localparam logic [wb_adr_w-1:0] reg_gain = 2'd1;
    // Command register, writes only, always reads back as zero
    localparam logic [wb_adr_w-1:0] reg_control = 2'd2;
    // FIFO fill count, read only
    localparam logic [wb_adr_w-1:0] reg_status = 2'd3;

    // Bit position of the gain enable inside reg_gain
    localparam int gain_enable_bit = 8;

    // Bit position of the flush request inside reg_control
    localparam int flush_bit = 0;

endpackage

// File: logic/sample_fifo.sv
//////////////////////////////////////////////////
// First-word-fall-through FIFO for calibrated
// samples with a fill count for the status register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_fifo import acq_pkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               flush,
    input  logic               wr_valid,
    output logic               wr_ready,
    input  sample_t            wr_data,
    output logic               rd_valid,
    input  logic               rd_ready,
    output sample_t            rd_data,
    output logic [count_w-1:0] count
);

    sample_t          mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_write;
    logic             do_read;

    // Full and empty come straight from the count
    assign wr_ready = (count != count_w'(fifo_depth));
    assign rd_valid = (count != '0);
    // The oldest word is always presented at the head
    assign rd_data = mem[rd_ptr];

    assign do_write = wr_valid && wr_ready;
    assign do_read = rd_valid && rd_ready;

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at the last entry, a flush empties the buffer
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leave the count as it is
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (rst) count <= count_w'(fifo_depth))
        else $error("FIFO count above depth");

    // A full FIFO that is not read keeps its write pointer, so no entry is overwritten
    assert property (@(posedge clock)
        (!rst && !flush && count == count_w'(fifo_depth) && !rd_ready) |=> $stable(wr_ptr))
        else $error("FIFO written while full");

endmodule

// File: logic/saturating_adder.sv
//////////////////////////////////////////////////
// Saturating adder, sums two signed samples and
// clamps the result to the sample range
//////////////////////////////////////////////////
`timescale 1ns/1ps

module saturating_adder import acq_pkg::*; (
    input  sample_t a,
    input  sample_t b,
    output sample_t sum
);

    // One guard bit above the sample catches any overflow
    logic signed [sample_w:0] wide_sum;

    assign wide_sum = $signed({a[sample_w-1], a}) + $signed({b[sample_w-1], b});

    // The two top bits disagree only when the true sum left the sample range
    always_comb begin
        if (wide_sum[sample_w] == 1'b0 && wide_sum[sample_w-1] == 1'b1) begin
            // Two positives wrapped into the sign bit
            sum = sample_max;
        end else if (wide_sum[sample_w] == 1'b1 && wide_sum[sample_w-1] == 1'b0) begin
            // Two negatives went below the most negative sample
            sum = sample_min;
        end else begin
            sum = wide_sum[sample_w-1:0];
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the acquisition front end testbench with Verilator and runs it into a log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_acq_frontend -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_acq_frontend > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The verdict comes from the log contents
if grep -qF "*** TEST FAILED ***" "$log"; then
    exit 1
fi
exit 0

// File: tests/tb_acq_frontend.sv
//////////////////////////////////////////////////
// Testbench for the acquisition front end that
// checks random streams against a calibration model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_acq_frontend import acq_pkg::*, regs_pkg::*; ();

    localparam int wait_limit = 400;

    logic clock;
    logic rst;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [wb_adr_w-1:0] wb_adr;
    logic [wb_dat_w-1:0] wb_wdata, wb_rdata;
    logic in_valid, in_ready, out_valid, out_ready;
    sample_t in_data, out_data;

    // The model settings mirror what was last written over Wishbone
    int seed, errors, checks, test_start, tests_failed, in_count, out_count;
    logic in_fire_last;
    sample_t expected_q[$];
    sample_t model_offset;
    logic [shift_w-1:0] model_shift;
    logic model_gain_en;

    acq_frontend u_dut (
        .clock (clock), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_wdata), .wb_dat_r (wb_rdata), .wb_ack (wb_ack),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data)
    );

    always #50 clock = ~clock;

    // The offset sum is clamped and then optionally shifted, keeping the low 16 bits
    function automatic sample_t expected_sample(sample_t value);
        int total;
        logic [31:0] shifted;
        sample_t clamped;
        total = int'(value) + int'(model_offset);
        if (total > int'(sample_max)) clamped = sample_max;
        else if (total < int'(sample_min)) clamped = sample_min;
        else clamped = 16'(total);
        shifted = 32'(clamped) << model_shift;
        return model_gain_en ? shifted[sample_w-1:0] : clamped;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic record_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // Both sides are sampled before the edge updates the DUT
    always @(posedge clock) begin
        in_fire_last = !rst && in_valid && in_ready;
        if (in_fire_last) begin
            expected_q.push_back(expected_sample(in_data));
            in_count++;
        end
        if (!rst && out_valid && out_ready) begin
            out_count++;
            assert (expected_q.size() != 0)
                else record_failure("Output transfer with no expected sample");
            if (expected_q.size() != 0) begin
                check_value("out_data", out_data, expected_q.pop_front());
            end
        end
    end

    // Bus tasks start and end on a falling edge and hold the request until ack
    task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [15:0] data);
        int waited;
        {wb_cyc, wb_stb, wb_we} = 3'b111;
        wb_adr = adr;
        wb_wdata = data;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!wb_ack && waited < wait_limit);
        assert (wb_ack) else record_failure("Wishbone write got no ack");
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [15:0] data);
        int waited;
        {wb_cyc, wb_stb, wb_we} = 3'b110;
        wb_adr = adr;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!wb_ack && waited < wait_limit);
        assert (wb_ack) else record_failure("Wishbone read got no ack");
        data = wb_rdata;
        {wb_cyc, wb_stb} = 2'b00;
    endtask

    task automatic set_offset(input sample_t value);
        wb_write(reg_offset, value);
        model_offset = value;
    endtask

    task automatic set_gain(input logic [shift_w-1:0] shift, input logic enable);
        logic [15:0] word;
        word = '0;
        word[shift_w-1:0] = shift;
        word[gain_enable_bit] = enable;
        wb_write(reg_gain, word);
        model_shift = shift;
        model_gain_en = enable;
    endtask

    // In_ready only depends on the FIFO count, so its mid-cycle value holds at the edge
    task automatic send_sample(input sample_t value);
        int waited;
        in_valid = 1'b1;
        in_data = value;
        waited = 0;
        while (!in_ready && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        assert (in_ready) else record_failure("Input sample was never accepted");
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < wait_limit) begin
            @(negedge clock);
            waited++;
        end
        assert (expected_q.size() == 0) else record_failure("Output stream did not drain");
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors != test_start) tests_failed++;
        $display("Test %0d %s: %s", num, name, (errors == test_start) ? "passed" : "failed");
        test_start = errors;
    endtask

    initial begin
        logic [15:0] rd, value;
        int raised, start_in, start_out, guard;
        seed = 32'h100bad23;
        {clock, rst, wb_cyc, wb_stb, wb_we, in_valid, out_ready} = 7'b0100000;
        {wb_adr, wb_wdata, in_data} = '0;
        {errors, checks, test_start, tests_failed, in_count, out_count} = '0;
        {model_offset, model_shift, model_gain_en} = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // Settings read back as written before a neutral configuration is restored
        value = 16'($random(seed));
        wb_write(reg_offset, value);
        wb_read(reg_offset, rd);
        check_value("wb_dat_r offset", rd, value);
        value = 16'h0100 | 16'($random(seed) & 15);
        wb_write(reg_gain, value);
        wb_read(reg_gain, rd);
        check_value("wb_dat_r gain", rd, value);
        wb_write(reg_control, 16'hfffe);
        wb_read(reg_control, rd);
        check_value("wb_dat_r control", rd, 16'h0000);
        wb_read(reg_status, rd);
        check_value("wb_dat_r status", rd, 16'h0000);
        set_offset(16'h0000);
        set_gain(4'd0, 1'b0);
        finish_test(1, "register readback");

        // Large offsets drive both clamp limits
        out_ready = 1'b1;
        for (int r = 0; r < 2; r++) begin
            set_offset(r == 0 ? 16'h7000 : 16'h9000);
            send_sample(sample_max);
            send_sample(sample_min);
            repeat (12) send_sample(16'($random(seed)));
        end
        wait_drain();
        finish_test(2, "offset saturation");

        set_offset(16'($random(seed) % 512));
        for (int r = 0; r < 6; r++) begin
            set_gain(4'($random(seed)), 1'b1);
            repeat (6) send_sample(16'($random(seed)));
        end
        wait_drain();
        finish_test(3, "gain shift");

        // A new random sample is offered only after the previous one has moved
        start_in = in_count;
        start_out = out_count;
        raised = 0;
        guard = 0;
        while (in_count - start_in < 64 && guard < 64 * 20) begin
            @(negedge clock);
            guard++;
            out_ready = 1'($random(seed));
            if (!in_valid || in_fire_last) begin
                in_valid = (raised < 64) && (($random(seed) & 3) != 0);
                in_data = 16'($random(seed));
                if (in_valid) raised++;
            end
        end
        in_valid = 1'b0;
        assert (in_count - start_in >= 64) else record_failure("Back-pressure stream stalled");
        out_ready = 1'b1;
        wait_drain();
        check_value("output transfer count", 16'(out_count - start_out), 16'(in_count - start_in));
        finish_test(4, "back-pressure");

        // FIFO full plus one sample held in the calibration register
        out_ready = 1'b0;
        guard = 0;
        while (in_ready && guard < 4 * fifo_depth) begin
            send_sample(16'($random(seed)));
            guard++;
        end
        assert (!in_ready) else record_failure("in_ready stayed high with out_ready held low");
        wb_read(reg_status, rd);
        check_value("wb_dat_r status", rd, 16'(fifo_depth));
        check_value("held sample count", 16'(expected_q.size()), 16'(fifo_depth + 1));
        finish_test(5, "fill count");

        // Everything buffered is discarded by the flush
        wb_write(reg_control, 16'(1 << flush_bit));
        expected_q.delete();
        guard = 0;
        while (out_valid && guard < wait_limit) begin
            @(negedge clock);
            guard++;
        end
        repeat (16) begin
            check_value("out_valid", 16'(out_valid), 16'h0000);
            @(negedge clock);
        end
        wb_read(reg_status, rd);
        check_value("wb_dat_r status", rd, 16'h0000);
        out_ready = 1'b1;
        repeat (8) send_sample(16'($random(seed)));
        wait_drain();
        finish_test(6, "flush");

        $display("Tests run: 6, failed: %0d, checks: %0d, errors: %0d", tests_failed, checks,
                 errors);
        if (errors == 0) $display("*** TEST PASSED ***");
        else $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
